// ==== logic/lcd_pkg.sv ====
/*
  widths, draw codes and LCD constants shared by the pet display blocks
  x positions are LCD columns 0..83, y positions are banks 0..5
  icons are one bank high; the bar reuses the icon position tables
*/
package lcd_pkg;

	// ----------------------------------------
	// types
	typedef logic [7:0] lcd_byte_t;      // command or display data
	typedef logic [4:0] col_idx_t;       // column inside one job
	typedef logic [3:0] level_t;         // hunger level from the core

	typedef enum logic [2:0] {
		DRAW_PEAR   = 3'd0,
		DRAW_CLOUD  = 3'd1,
		DRAW_HEART  = 3'd2,
		DRAW_CARROT = 3'd3,
		DRAW_CROSS  = 3'd4,
		DRAW_BAR    = 3'd5
	} draw_code_t;

	typedef enum logic [2:0] {
		BOOT_RESET = 3'd0,
		BOOT_INIT  = 3'd1,
		BOOT_CLEAR = 3'd2,
		SERVE_IDLE = 3'd3,
		SERVE_DRAW = 3'd4
	} boot_state_t;

	// ----------------------------------------
	// LCD command set
	// extended set, Vop, basic set, normal mode
	localparam lcd_byte_t INIT_CMD [4] = '{8'h21, 8'h90, 8'h20, 8'h0C};
	localparam int        CLEAR_BYTES  = 504;    // 84 columns x 6 banks
	localparam lcd_byte_t SET_X_BASE   = 8'h80;
	localparam lcd_byte_t SET_Y_BASE   = 8'h40;

	// ----------------------------------------
	// placement, indexed by draw_code_t
	localparam lcd_byte_t ICON_X [6] = '{8'd0, 8'd27, 8'd56, 8'd14, 8'd26, 8'd9};
	localparam lcd_byte_t ICON_Y [6] = '{8'd0, 8'd0, 8'd0, 8'd3, 8'd2, 8'd0};

	localparam int        BAR_COLS = 16;
	localparam lcd_byte_t BAR_FILL = 8'h7E;      // filled column, rows 1..6

	// columns per job, the bar entry is BAR_COLS
	localparam col_idx_t ICON_W [6] = '{5'd7, 5'd9, 5'd9, 5'd9, 5'd8, 5'(BAR_COLS)};

	// ----------------------------------------
	// timing
	localparam int SCLK_DIV       = 4;   // system clocks per sclk half-period
	localparam int LCD_RST_CYCLES = 8;   // lcd reset hold after rst_n release

endpackage

// ==== logic/lcd_spi_tx.sv ====
/*
  write-only SPI byte sender, mode 0, MSB first
  one byte takes 16*SCLK_DIV+2 cycles from accept until tx_ready returns
  dc is latched at accept and held while sce is low
*/
`timescale 1ns/10ps

module lcd_spi_tx (
	input  logic                clock,
	input  logic                rst_n,
	input  lcd_pkg::lcd_byte_t  tx_byte,
	input  logic                tx_dc,
	input  logic                tx_valid,
	output logic                tx_ready,
	output logic                sce,
	output logic                sclk,
	output logic                mosi,
	output logic                dc
);

	localparam int DIV_W = (lcd_pkg::SCLK_DIV > 1) ? $clog2(lcd_pkg::SCLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(lcd_pkg::SCLK_DIV - 1);

	logic               busy;
	logic [DIV_W-1:0]   div_cnt;
	logic [4:0]         half_cnt;   // 0..15 shifting, 16 and 17 tail
	lcd_pkg::lcd_byte_t shreg;
	logic               dc_q;
	logic               half_tick;

	assign half_tick = busy && (half_cnt < 5'd16) && (div_cnt == DIV_LAST);

	// ----------------------------------------
	// control
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			sce      <= 1'b1;
			sclk     <= 1'b0;
			div_cnt  <= '0;
			half_cnt <= '0;
		end else if (!busy) begin
			if (tx_valid) begin
				busy     <= 1'b1;
				sce      <= 1'b0;
				div_cnt  <= '0;
				half_cnt <= '0;
			end
		end else if (half_cnt < 5'd16) begin
			if (div_cnt == DIV_LAST) begin
				div_cnt  <= '0;
				half_cnt <= half_cnt + 5'd1;
				sclk     <= ~sclk;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end else if (half_cnt == 5'd16) begin
			half_cnt <= 5'd17;      // hold sce low one more cycle
		end else begin
			busy <= 1'b0;
			sce  <= 1'b1;
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (!busy && tx_valid) begin
			shreg <= tx_byte;
			dc_q  <= tx_dc;
		end else if (half_tick && sclk) begin
			shreg <= {shreg[6:0], 1'b0};   // next bit on falling sclk
		end
	end

	assign tx_ready = ~busy;
	assign mosi     = shreg[7];
	assign dc       = dc_q;

endmodule

// ==== logic/lcd_sprite_rom.sv ====
/*
  column patterns of the five single-bank icons, bit 0 is the top pixel
  columns at or past the icon width read as zero, the bar row is blank
*/
`timescale 1ns/10ps

module lcd_sprite_rom (
	input  lcd_pkg::draw_code_t code,
	input  lcd_pkg::col_idx_t   col,
	output lcd_pkg::lcd_byte_t  pixels,
	output lcd_pkg::col_idx_t   width
);

	localparam int MAX_W = 9;

	// ----------------------------------------
	localparam lcd_pkg::lcd_byte_t COLS [6][MAX_W] = '{
		// pear
		'{8'h30, 8'h48, 8'h84, 8'h82, 8'h87, 8'h49, 8'h30, 8'h00, 8'h00},
		// cloud
		'{8'h18, 8'h24, 8'h42, 8'h41, 8'h41, 8'h41, 8'h42, 8'h24, 8'h18},
		// heart
		'{8'h0C, 8'h12, 8'h21, 8'h41, 8'h82, 8'h41, 8'h21, 8'h12, 8'h0C},
		// carrot top
		'{8'h80, 8'hC0, 8'h40, 8'h40, 8'h78, 8'h4E, 8'hC2, 8'h3E, 8'h20},
		// cross
		'{8'h3C, 8'h24, 8'hE7, 8'h81, 8'h81, 8'hE7, 8'h24, 8'h3C, 8'h00},
		// bar, filled by the engine
		'{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
	};

	always_comb begin
		width  = lcd_pkg::ICON_W[code];
		pixels = '0;
		if ((col < width) && (col < 5'(MAX_W))) begin
			pixels = COLS[code][col[3:0]];
		end
	end

endmodule

// ==== logic/lcd_draw_engine.sv ====
/*
  one draw job: set X, set Y, then the data columns of an icon or the bar
  address bytes go with dc low, data with dc high
  job_done pulses the cycle after the last data byte is taken
*/
`timescale 1ns/10ps

module lcd_draw_engine (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                job_valid,
	input  lcd_pkg::draw_code_t job_code,
	input  lcd_pkg::level_t     job_level,
	input  logic                tx_ready,
	output logic                job_ready,
	output logic                job_done,
	output lcd_pkg::lcd_byte_t  tx_byte,
	output logic                tx_dc,
	output logic                tx_valid
);

	typedef enum logic [1:0] {
		E_IDLE  = 2'd0,
		E_SET_X = 2'd1,
		E_SET_Y = 2'd2,
		E_DATA  = 2'd3
	} eng_state_t;

	eng_state_t          state;
	lcd_pkg::draw_code_t code_q;
	lcd_pkg::level_t     level_q;
	lcd_pkg::col_idx_t   col;
	lcd_pkg::lcd_byte_t  rom_pixels;
	lcd_pkg::col_idx_t   rom_width;
	lcd_pkg::lcd_byte_t  bar_byte;
	logic                last_col;

	lcd_sprite_rom u_rom (
		.code   (code_q),
		.col    (col),
		.pixels (rom_pixels),
		.width  (rom_width)
	);

	assign bar_byte = (col < {1'b0, level_q}) ? lcd_pkg::BAR_FILL : '0;
	assign last_col = (col == rom_width - 5'd1);

	// ----------------------------------------
	// byte channel
	assign job_ready = (state == E_IDLE);
	assign tx_valid  = (state != E_IDLE);
	assign tx_dc     = (state == E_DATA);

	always_comb begin
		case (state)
			E_SET_X: tx_byte = lcd_pkg::SET_X_BASE | lcd_pkg::ICON_X[code_q];
			E_SET_Y: tx_byte = lcd_pkg::SET_Y_BASE | lcd_pkg::ICON_Y[code_q];
			E_DATA:  tx_byte = (code_q == lcd_pkg::DRAW_BAR) ? bar_byte : rom_pixels;
			default: tx_byte = '0;
		endcase
	end

	// ----------------------------------------
	// sequencing
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state    <= E_IDLE;
			job_done <= 1'b0;
		end else begin
			job_done <= 1'b0;
			case (state)
				E_IDLE: if (job_valid) state <= E_SET_X;
				E_SET_X: if (tx_ready) state <= E_SET_Y;
				E_SET_Y: if (tx_ready) state <= E_DATA;
				E_DATA: begin
					if (tx_ready && last_col) begin
						state    <= E_IDLE;
						job_done <= 1'b1;
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

	// job fields and column counter
	always_ff @(posedge clock) begin
		if (state == E_IDLE) begin
			if (job_valid) begin
				code_q  <= job_code;
				level_q <= job_level;
			end
			col <= '0;
		end else if (state == E_DATA && tx_ready) begin
			col <= col + 5'd1;
		end
	end

endmodule

// ==== logic/lcd_pet_ctrl.sv ====
/*
  boot sequence: LCD reset pulse, init commands, full clear
  then forwards one draw request at a time to the draw engine
  ready rises only once the SPI link is idle
*/
`timescale 1ns/10ps

module lcd_pet_ctrl (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                draw_valid,
	input  lcd_pkg::draw_code_t draw_code,
	input  lcd_pkg::level_t     hunger_level,
	input  logic                tx_ready,
	input  logic                job_ready,
	input  logic                job_done,
	output logic                lcd_rst_n,
	output logic                ready,
	output logic                done,
	output logic                job_valid,
	output lcd_pkg::draw_code_t job_code,
	output lcd_pkg::level_t     job_level,
	output logic                engine_active,
	output lcd_pkg::lcd_byte_t  tx_byte,
	output logic                tx_dc,
	output logic                tx_valid
);

	localparam int RST_W = $clog2(lcd_pkg::LCD_RST_CYCLES + 1);
	localparam logic [8:0] CLEAR_LAST = 9'(lcd_pkg::CLEAR_BYTES - 1);

	lcd_pkg::boot_state_t state;
	logic [RST_W-1:0]     rst_cnt;
	logic [8:0]           byte_cnt;    // init index, then clear count

	// ----------------------------------------
	// boot byte source
	always_comb begin
		tx_valid = 1'b0;
		tx_dc    = 1'b0;
		tx_byte  = '0;
		case (state)
			lcd_pkg::BOOT_INIT: begin
				tx_valid = 1'b1;
				tx_byte  = lcd_pkg::INIT_CMD[byte_cnt[1:0]];
			end
			lcd_pkg::BOOT_CLEAR: begin
				tx_valid = 1'b1;
				tx_dc    = 1'b1;      // zero data bytes
			end
			default: ;
		endcase
	end

	assign engine_active = (state == lcd_pkg::SERVE_DRAW);

	// ----------------------------------------
	// boot and serve FSM
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state     <= lcd_pkg::BOOT_RESET;
			rst_cnt   <= '0;
			byte_cnt  <= '0;
			lcd_rst_n <= 1'b0;
			ready     <= 1'b0;
			done      <= 1'b0;
			job_valid <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				lcd_pkg::BOOT_RESET: begin
					rst_cnt <= rst_cnt + 1'b1;
					if (rst_cnt == RST_W'(lcd_pkg::LCD_RST_CYCLES - 1)) begin
						lcd_rst_n <= 1'b1;
						state     <= lcd_pkg::BOOT_INIT;
					end
				end
				lcd_pkg::BOOT_INIT: begin
					if (tx_ready) begin
						byte_cnt <= byte_cnt + 9'd1;
						if (byte_cnt == 9'd3) begin
							byte_cnt <= '0;
							state    <= lcd_pkg::BOOT_CLEAR;
						end
					end
				end
				lcd_pkg::BOOT_CLEAR: begin
					if (tx_ready) begin
						byte_cnt <= byte_cnt + 9'd1;
						if (byte_cnt == CLEAR_LAST) state <= lcd_pkg::SERVE_IDLE;
					end
				end
				lcd_pkg::SERVE_IDLE: begin
					if (!ready) begin
						ready <= tx_ready;    // wait out the last byte on the wire
					end else if (draw_valid) begin
						ready     <= 1'b0;
						job_valid <= 1'b1;
						state     <= lcd_pkg::SERVE_DRAW;
					end
				end
				lcd_pkg::SERVE_DRAW: begin
					if (job_valid && job_ready) job_valid <= 1'b0;
					if (job_done) begin
						done  <= 1'b1;
						state <= lcd_pkg::SERVE_IDLE;
					end
				end
				default: state <= lcd_pkg::BOOT_RESET;
			endcase
		end
	end

	// request fields, sampled on accept
	always_ff @(posedge clock) begin
		if (state == lcd_pkg::SERVE_IDLE && ready && draw_valid) begin
			job_code  <= draw_code;
			job_level <= hunger_level;
		end
	end

endmodule

// ==== logic/lcd_pet_top.sv ====
/*
  pet display top: controller, draw engine and SPI sender
  the byte channel belongs to the engine while engine_active is high
*/
`timescale 1ns/10ps

module lcd_pet_top (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                draw_valid,
	input  lcd_pkg::draw_code_t draw_code,
	input  lcd_pkg::level_t     hunger_level,
	output logic                ready,
	output logic                done,
	output logic                sce,
	output logic                sclk,
	output logic                mosi,
	output logic                dc,
	output logic                lcd_rst_n
);

	logic                engine_active;
	logic                job_valid;
	logic                job_ready;
	logic                job_done;
	lcd_pkg::draw_code_t job_code;
	lcd_pkg::level_t     job_level;
	lcd_pkg::lcd_byte_t  ctl_tx_byte;
	logic                ctl_tx_dc;
	logic                ctl_tx_valid;
	lcd_pkg::lcd_byte_t  eng_tx_byte;
	logic                eng_tx_dc;
	logic                eng_tx_valid;
	lcd_pkg::lcd_byte_t  tx_byte;
	logic                tx_dc;
	logic                tx_valid;
	logic                tx_ready;

	// ----------------------------------------
	// byte channel owner
	assign tx_byte  = engine_active ? eng_tx_byte  : ctl_tx_byte;
	assign tx_dc    = engine_active ? eng_tx_dc    : ctl_tx_dc;
	assign tx_valid = engine_active ? eng_tx_valid : ctl_tx_valid;

	lcd_pet_ctrl u_ctrl (
		.clock         (clock),
		.rst_n         (rst_n),
		.draw_valid    (draw_valid),
		.draw_code     (draw_code),
		.hunger_level  (hunger_level),
		.tx_ready      (tx_ready),
		.job_ready     (job_ready),
		.job_done      (job_done),
		.lcd_rst_n     (lcd_rst_n),
		.ready         (ready),
		.done          (done),
		.job_valid     (job_valid),
		.job_code      (job_code),
		.job_level     (job_level),
		.engine_active (engine_active),
		.tx_byte       (ctl_tx_byte),
		.tx_dc         (ctl_tx_dc),
		.tx_valid      (ctl_tx_valid)
	);

	lcd_draw_engine u_engine (
		.clock     (clock),
		.rst_n     (rst_n),
		.job_valid (job_valid),
		.job_code  (job_code),
		.job_level (job_level),
		.tx_ready  (tx_ready),
		.job_ready (job_ready),
		.job_done  (job_done),
		.tx_byte   (eng_tx_byte),
		.tx_dc     (eng_tx_dc),
		.tx_valid  (eng_tx_valid)
	);

	lcd_spi_tx u_spi (
		.clock    (clock),
		.rst_n    (rst_n),
		.tx_byte  (tx_byte),
		.tx_dc    (tx_dc),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.sce      (sce),
		.sclk     (sclk),
		.mosi     (mosi),
		.dc       (dc)
	);

endmodule

// ==== sim/lcd_pet_asserts.sv ====
/*
  bound into lcd_pet_top, compares decoded SPI bytes with the expected stream
  the decoded bytes and the expected queue head come from the testbench
  icon data bytes marked wild are checked for dc only
*/
`timescale 1ns/10ps

module lcd_pet_asserts (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               draw_valid,
	input  logic               ready,
	input  logic               done,
	input  logic               sce,
	input  logic               sclk,
	input  logic               dc,
	input  logic               lcd_rst_n,
	input  logic               mon_strobe,
	input  lcd_pkg::lcd_byte_t mon_byte,
	input  logic               mon_dc,
	input  int                 exp_count,
	input  lcd_pkg::lcd_byte_t exp_byte,
	input  logic               exp_dc,
	input  logic               exp_wild,
	input  logic               tests_done
);

	logic       fail_seen;
	logic [4:0] since_rst;      // cycles since rst_n rose, saturating
	logic       in_flight;      // accepted request not yet done

	initial fail_seen = 1'b0;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			since_rst <= '0;
			in_flight <= 1'b0;
		end else begin
			if (since_rst != '1) since_rst <= since_rst + 5'd1;
			if (ready && draw_valid) begin
				in_flight <= 1'b1;
			end else if (done) begin
				in_flight <= 1'b0;
			end
		end
	end

	// ----------------------------------------
	// boot
	a_rst_hold: assert property (@(posedge clock) disable iff (!rst_n)
		since_rst < 5'(lcd_pkg::LCD_RST_CYCLES) |-> !lcd_rst_n && sce && !sclk && !ready && !done)
	else begin
		$error("LCD reset or idle lines were wrong during the reset hold");
		fail_seen = 1'b1;
	end

	a_rst_release: assert property (@(posedge clock) disable iff (!rst_n)
		since_rst == 5'(lcd_pkg::LCD_RST_CYCLES) |-> lcd_rst_n)
	else begin
		$error("LCD reset was still held after its hold time");
		fail_seen = 1'b1;
	end

	// ----------------------------------------
	// byte stream
	a_no_extra: assert property (@(posedge clock) disable iff (!rst_n)
		mon_strobe |-> exp_count != 0)
	else begin
		$error("an SPI byte arrived when none was expected");
		fail_seen = 1'b1;
	end

	a_byte: assert property (@(posedge clock) disable iff (!rst_n)
		mon_strobe && exp_count != 0 |-> mon_dc == exp_dc && (exp_wild || mon_byte == exp_byte))
	else begin
		$error("mismatch at %0t: got %h dc %b, expected %h dc %b", $time, $sampled(mon_byte),
			$sampled(mon_dc), $sampled(exp_byte), $sampled(exp_dc));
		fail_seen = 1'b1;
	end

	a_dc_stable: assert property (@(posedge clock) disable iff (!rst_n)
		!sce && $past(!sce) |-> $stable(dc))
	else begin
		$error("dc changed while sce was low");
		fail_seen = 1'b1;
	end

	// ----------------------------------------
	// request handshake
	a_done_pulse: assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
	else begin
		$error("done stayed high for more than one cycle");
		fail_seen = 1'b1;
	end

	a_done_owned: assert property (@(posedge clock) disable iff (!rst_n) done |-> in_flight)
	else begin
		$error("done pulsed without an accepted request");
		fail_seen = 1'b1;
	end

	a_busy: assert property (@(posedge clock) disable iff (!rst_n) in_flight |-> !ready)
	else begin
		$error("ready was high while a request was in flight");
		fail_seen = 1'b1;
	end

	a_drained: assert property (@(posedge clock) disable iff (!rst_n)
		tests_done |-> exp_count == 0 && !in_flight)
	else begin
		$error("mismatch at %0t: %0d expected bytes never arrived", $time, $sampled(exp_count));
		fail_seen = 1'b1;
	end

endmodule

// ==== sim/tb_lcd_pet.sv ====
/*
  boots the pet display, then issues twelve draw requests, some held while busy
  expected LCD bytes are queued here and lcd_pet_asserts does the comparing
  only the count and dc of icon data bytes are known here
*/
`timescale 1ns/10ps

module tb_lcd_pet;

	localparam int N_REQ          = 12;
	localparam int TIMEOUT_CYCLES = 120000;  // (508 + 12*18) bytes x 66 cycles plus margin

	logic                clock;
	logic                rst_n;
	logic                draw_valid;
	lcd_pkg::draw_code_t draw_code;
	lcd_pkg::level_t     hunger_level;
	logic                ready;
	logic                done;
	logic                sce;
	logic                sclk;
	logic                mosi;
	logic                dc;
	logic                lcd_rst_n;

	logic                sclk_q;
	logic                sce_q;
	lcd_pkg::lcd_byte_t  shift_bits;
	logic                mon_strobe;
	lcd_pkg::lcd_byte_t  mon_byte;
	logic                mon_dc;

	logic [9:0]          exp_q [$];       // {wild, dc, byte}
	int                  exp_count;
	lcd_pkg::lcd_byte_t  exp_byte;
	logic                exp_dc;
	logic                exp_wild;
	logic                tests_done;
	int                  cycle_cnt;
	int                  seed;

	lcd_pet_top uut (
		.clock        (clock),
		.rst_n        (rst_n),
		.draw_valid   (draw_valid),
		.draw_code    (draw_code),
		.hunger_level (hunger_level),
		.ready        (ready),
		.done         (done),
		.sce          (sce),
		.sclk         (sclk),
		.mosi         (mosi),
		.dc           (dc),
		.lcd_rst_n    (lcd_rst_n)
	);

	bind lcd_pet_top lcd_pet_asserts u_chk (
		.clock      (clock),
		.rst_n      (rst_n),
		.draw_valid (draw_valid),
		.ready      (ready),
		.done       (done),
		.sce        (sce),
		.sclk       (sclk),
		.dc         (dc),
		.lcd_rst_n  (lcd_rst_n),
		.mon_strobe (tb_lcd_pet.mon_strobe),
		.mon_byte   (tb_lcd_pet.mon_byte),
		.mon_dc     (tb_lcd_pet.mon_dc),
		.exp_count  (tb_lcd_pet.exp_count),
		.exp_byte   (tb_lcd_pet.exp_byte),
		.exp_dc     (tb_lcd_pet.exp_dc),
		.exp_wild   (tb_lcd_pet.exp_wild),
		.tests_done (tb_lcd_pet.tests_done)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ----------------------------------------
	// expected bytes
	task automatic load_boot_bytes();
		int i;
		for (i = 0; i < 4; i++) exp_q.push_back({2'b00, lcd_pkg::INIT_CMD[i]});
		for (i = 0; i < lcd_pkg::CLEAR_BYTES; i++) exp_q.push_back({2'b01, 8'h00});
	endtask

	task automatic queue_request(input lcd_pkg::draw_code_t code, input lcd_pkg::level_t level);
		int n_cols;
		int c;
		exp_q.push_back({2'b00, lcd_pkg::SET_X_BASE + lcd_pkg::ICON_X[code]});
		exp_q.push_back({2'b00, lcd_pkg::SET_Y_BASE + lcd_pkg::ICON_Y[code]});
		n_cols = (code == lcd_pkg::DRAW_BAR) ? lcd_pkg::BAR_COLS : int'(lcd_pkg::ICON_W[code]);
		for (c = 0; c < n_cols; c++) begin
			if (code == lcd_pkg::DRAW_BAR) begin
				exp_q.push_back({2'b01, (c < int'(level)) ? lcd_pkg::BAR_FILL : 8'h00});
			end else begin
				exp_q.push_back({2'b11, 8'h00});     // icon pixels may take any value
			end
		end
	endtask

	always @(posedge clock) begin
		if (mon_strobe && exp_q.size() > 0) exp_q.delete(0);
		if (draw_valid && ready) queue_request(draw_code, hunger_level);
		exp_count <= exp_q.size();
		if (exp_q.size() > 0) {exp_wild, exp_dc, exp_byte} <= exp_q[0];
	end

	// ----------------------------------------
	// SPI monitor, mode 0
	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			sclk_q     <= 1'b0;
			sce_q      <= 1'b1;
			shift_bits <= '0;
			mon_strobe <= 1'b0;
			mon_byte   <= '0;
			mon_dc     <= 1'b0;
		end else begin
			sclk_q     <= sclk;
			sce_q      <= sce;
			mon_strobe <= sce && !sce_q;
			if (sclk && !sclk_q && !sce) shift_bits <= {shift_bits[6:0], mosi};
			if (sce && !sce_q) begin
				mon_byte <= shift_bits;
				mon_dc   <= dc;
			end
		end
	end

	// failure and timeout watch
	always @(posedge clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (uut.u_chk.fail_seen) begin
			$display("** FAIL **");
			$fatal(1, "stopped at the first assertion error");
		end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("** FAIL **");
			$fatal(1, "timeout after %0d cycles waiting for the DUT", cycle_cnt);
		end
	end

	// ----------------------------------------
	// stimulus
	task automatic send_request(input int code, input int level, input bit early);
		if (!early) begin
			while (!ready) @(negedge clock);
		end
		draw_valid   = 1'b1;
		draw_code    = lcd_pkg::draw_code_t'(3'(code));
		hunger_level = lcd_pkg::level_t'(level);
		while (!ready) @(negedge clock);
		@(negedge clock);                        // accepted on the last edge
		draw_valid   = 1'b0;
		draw_code    = lcd_pkg::draw_code_t'(3'(5 - code));   // stale fields must not leak in
		hunger_level = ~hunger_level;
		while (!done) @(negedge clock);
	endtask

	initial begin
		int  i;
		int  code;
		int  level;
		int  gap;
		bit  early;
		seed         = 32'h0b901774;
		cycle_cnt    = 0;
		rst_n        = 1'b0;
		draw_valid   = 1'b0;
		draw_code    = lcd_pkg::DRAW_PEAR;
		hunger_level = '0;
		tests_done   = 1'b0;
		load_boot_bytes();
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
		while (!ready) @(negedge clock);
		for (i = 0; i < N_REQ; i++) begin
			code  = (i % 2 == 0) ? i / 2 : int'($unsigned($random(seed)) % 6);
			level = $random(seed) & 15;
			early = (i > 0) && ((i % 3 == 1) || (($random(seed) & 1) != 0));
			if (!early) begin
				gap = $random(seed) & 7;
				repeat (gap) @(negedge clock);
			end
			send_request(code, level, early);
		end
		while (!ready) @(negedge clock);
		repeat (4) @(negedge clock);
		tests_done = 1'b1;
		@(negedge clock);
		tests_done = 1'b0;
		repeat (2) @(negedge clock);
		if (uut.u_chk.fail_seen) begin
			$display("** FAIL **");
			$fatal(1, "assertion errors were reported");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// ==== compile.f ====
logic/lcd_pkg.sv
logic/lcd_spi_tx.sv
logic/lcd_sprite_rom.sv
logic/lcd_draw_engine.sv
logic/lcd_pet_ctrl.sv
logic/lcd_pet_top.sv
sim/lcd_pet_asserts.sv
sim/tb_lcd_pet.sv

// ==== Makefile ====
# Verilator build and run for the pet LCD controller

TOP = tb_lcd_pet

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --top-module lcd_pet_top logic/lcd_pkg.sv logic/lcd_spi_tx.sv \
		logic/lcd_sprite_rom.sv logic/lcd_draw_engine.sv logic/lcd_pet_ctrl.sv logic/lcd_pet_top.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

obj_dir/V$(TOP): compile.f $(wildcard logic/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -qF '** FAIL **' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '** PASS **' sim.log; then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
